// File: sources.f
source/wbm_spi_pkg.sv
source/spi_byte_rx.sv
source/spi_byte_tx.sv
source/cdc_import.sv
source/cdc_export.sv
source/wbm_spi.sv
source/wb_word_ram.sv
source/spi_wb_bridge_top.sv
tests/tb_spi_wb_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI to Wishbone bridge testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_spi_wb_bridge -f sources.f \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

// File: tests/tb_spi_wb_bridge.sv
// Testbench for the SPI to Wishbone bridge
// Acts as SPI master in mode 0, keeps a reference word memory
// and checks every reply byte that comes back on spi_sdo_o
`timescale 1ns/1ps
`default_nettype none

module tb_spi_wb_bridge import wbm_spi_pkg::*; ();

	localparam int n_rows = 14;
	localparam int half_sck = 4;                     // wb_clk_i cycles per SCK phase
	localparam int spi_period_ns = 2 * half_sck * 8;
	localparam int frame_bits = 12 * byte_w;         // Longest frame plus margin
	localparam int max_fill = 4;                     // Fillers allowed before the ack
	localparam int timeout_ns = n_rows * frame_bits * spi_period_ns * 4 + 200;

	logic wb_clk_i, wb_rst_i;
	logic spi_sck_i, spi_csn_i, spi_sdi_i;
	logic spi_sdo_o, tx_ready_o;

	// Stimulus table, one frame per row
	logic tbl_we [n_rows];
	logic [sel_w-1:0] tbl_sel [n_rows];
	logic [byte_w-1:0] tbl_adr [n_rows];  // Word address
	logic [word_w-1:0] tbl_wdat [n_rows];
	logic [word_w-1:0] tbl_exp [n_rows];  // Reference word after the row
	int tbl_lead [n_rows];                // Idle 0x00 bytes ahead of the command
	int row_cnt;

	logic [word_w-1:0] ref_mem [mem_words];
	logic [31:0] lfsr_q;
	int n_checks, n_errors, rows_failed;

	spi_wb_bridge_top u_spi_wb_bridge_top (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.spi_sck_i(spi_sck_i), .spi_csn_i(spi_csn_i), .spi_sdi_i(spi_sdi_i),
		.spi_sdo_o(spi_sdo_o), .tx_ready_o(tx_ready_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #4 wb_clk_i = ~wb_clk_i; // 8 ns period
	end

	// Watchdog sized from the table length
	initial begin
		#(timeout_ns);
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		$display("Test failed");
		$finish;
	end

	// Galois LFSR, right shifting
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		return s >> 1;
	endfunction

	function automatic logic [word_w-1:0] random_word();
		logic [word_w-1:0] w;
		w = '0;
		for (int i = 0; i < word_w; i++) begin
			w = {w[word_w-2:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q); // One step per bit taken
		end
		return w;
	endfunction

	// Appends a row and applies the byte select rule to the reference memory
	task automatic add_row(input logic we, input logic [sel_w-1:0] sel,
			input logic [byte_w-1:0] adr, input int lead);
		tbl_we[row_cnt] = we;
		tbl_sel[row_cnt] = sel;
		tbl_adr[row_cnt] = adr;
		tbl_lead[row_cnt] = lead;
		tbl_wdat[row_cnt] = '0;
		if (we) begin
			tbl_wdat[row_cnt] = random_word();
			for (int i = 0; i < sel_w; i++) begin
				if (sel[i])
					ref_mem[adr][i*byte_w +: byte_w] = tbl_wdat[row_cnt][i*byte_w +: byte_w];
			end
		end
		tbl_exp[row_cnt] = ref_mem[adr];
		row_cnt++;
	endtask

	task automatic load_table();
		add_row(1'b1, 4'hF, 8'h10, 0); // Full write then read back
		add_row(1'b0, 4'hF, 8'h10, 0);
		add_row(1'b1, 4'h5, 8'h10, 1); // Partial over a full word
		add_row(1'b1, 4'hA, 8'h20, 0); // Partial over zero
		add_row(1'b0, 4'hF, 8'h10, 0);
		add_row(1'b1, 4'hF, 8'h00, 0); // Lowest address
		add_row(1'b1, 4'hF, 8'hFF, 2); // Highest address
		add_row(1'b1, 4'h3, 8'hFF, 0);
		add_row(1'b0, 4'hF, 8'h00, 0);
		add_row(1'b0, 4'hF, 8'hFF, 0);
		add_row(1'b0, 4'hF, 8'h20, 1);
		add_row(1'b1, 4'h8, 8'h00, 0); // Top byte only
		add_row(1'b0, 4'hF, 8'h00, 0);
		add_row(1'b0, 4'hF, 8'h42, 0); // Never written
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Drives land 1 ns after the rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge wb_clk_i);
		#1;
	endtask

	// Mode 0 byte, MSB first, SCK low on entry and exit
	task automatic spi_byte(input logic [byte_w-1:0] tx, output logic [byte_w-1:0] rx);
		for (int i = byte_w - 1; i >= 0; i--) begin
			spi_sdi_i = tx[i];   // Setup before the rising edge
			tick(half_sck);
			rx[i] = spi_sdo_o;   // Stable since the last falling edge
			spi_sck_i = 1'b1;
			tick(half_sck);
			spi_sck_i = 1'b0;    // DUT shifts SDO here
		end
	endtask

	task automatic run_frame(input int r);
		logic [byte_w-1:0] cmd, rep;
		logic [word_w-1:0] got;
		int n_fill;
		logic seen_ack;
		got = '0;
		n_fill = 0;
		seen_ack = 1'b0;
		cmd = {tbl_we[r], {(byte_w - 1 - sel_w){1'b0}}, tbl_sel[r]};
		for (int i = 0; i < tbl_lead[r]; i++) begin
			spi_byte(8'h00, rep); // Skipped by the sequencer
			check_value("reply during idle filler", 32'(rep), 32'(reply_wait));
		end
		spi_byte(cmd, rep);
		check_value("reply during command", 32'(rep), 32'(reply_wait));
		spi_byte(tbl_adr[r], rep);
		check_value("reply during address", 32'(rep), 32'(reply_wait));
		if (tbl_we[r]) begin
			for (int b = sel_w - 1; b >= 0; b--) begin
				spi_byte(tbl_wdat[r][b*byte_w +: byte_w], rep); // MSB first
				check_value("reply during write data", 32'(rep), 32'(reply_wait));
			end
		end
		// Replies lag one byte behind
		while (!seen_ack && n_fill < max_fill) begin
			spi_byte(8'h00, rep);
			n_fill++;
			if (rep == reply_ack)
				seen_ack = 1'b1;
			else
				check_value("reply while pending", 32'(rep), 32'(reply_wait));
		end
		if (!seen_ack) begin
			n_errors++;
			$display("No acknowledge reply after %0d filler bytes", max_fill);
		end else if (!tbl_we[r]) begin
			for (int b = 0; b < sel_w; b++) begin
				spi_byte(8'h00, rep);
				got = {got[word_w-byte_w-1:0], rep}; // MSB arrives first
			end
			check_value("read data", got, tbl_exp[r]);
		end
	endtask

	// Last reply toggle must come back through the crossing
	task automatic wait_ready(input string when);
		int n;
		n = 0;
		n_checks++;
		while (!tx_ready_o && n < 32) begin
			tick(1);
			n++;
		end
		if (!tx_ready_o) begin
			n_errors++;
			$display("tx_ready_o stayed low %s", when);
		end
	endtask

	initial begin
		int errs_before;
		seq_state_t st;
		wb_rst_i = 1'b1;
		spi_csn_i = 1'b1; // Clears both SPI shifters
		spi_sck_i = 1'b0;
		spi_sdi_i = 1'b0;
		n_checks = 0;
		n_errors = 0;
		rows_failed = 0;
		row_cnt = 0;
		lfsr_q = 32'd70094;
		for (int a = 0; a < mem_words; a++)
			ref_mem[a] = '0;
		load_table();
		tick(16);
		wb_rst_i = 1'b0;
		wait_ready("after reset");
		spi_csn_i = 1'b0; // Selected for the whole run
		tick(half_sck);
		for (int r = 0; r < n_rows; r++) begin
			errs_before = n_errors;
			run_frame(r);
			wait_ready("after the frame");
			st = u_spi_wb_bridge_top.u_wbm_spi.state;
			if (n_errors != errs_before)
				rows_failed++;
			$display("row %0d: %s adr %02h sel %h word %08h, sequencer %s, %s", r,
				tbl_we[r] ? "write" : "read", tbl_adr[r], tbl_sel[r],
				tbl_we[r] ? tbl_wdat[r] : tbl_exp[r], st.name(),
				(n_errors == errs_before) ? "ok" : "FAILED");
		end
		$display("rows %0d, rows failed %0d, checks %0d, errors %0d",
			n_rows, rows_failed, n_checks, n_errors);
		if (n_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/spi_wb_bridge_top.sv
// SPI to Wishbone bridge subsystem
// SPI shifters, both clock crossings, the sequencer and a word memory slave
`timescale 1ns/1ps
`default_nettype none

module spi_wb_bridge_top import wbm_spi_pkg::*; (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	input  logic spi_sck_i,
	input  logic spi_csn_i,
	input  logic spi_sdi_i,
	output logic spi_sdo_o,
	output logic tx_ready_o
);

	// SPI to bus
	logic rx_req, rx_ack, rx_stb;
	logic [byte_w-1:0] rx_data, rx_byte;
	// Bus to SPI
	logic tx_stb, tx_req, tx_ack;
	logic [byte_w-1:0] tx_data, tx_data_x;
	// Wishbone
	logic wb_cyc, wb_stb, wb_we, wb_stall, wb_ack;
	logic [sel_w-1:0] wb_sel;
	logic [adr_w-1:0] wb_adr;
	logic [word_w-1:0] wb_dat_w, wb_dat_r;

	spi_byte_rx u_spi_byte_rx (
		.spi_sck_i(spi_sck_i), .spi_csn_i(spi_csn_i), .spi_sdi_i(spi_sdi_i),
		.rx_ack_i(rx_ack), .rx_req_o(rx_req), .rx_data_o(rx_data)
	);

	cdc_import u_cdc_import (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .req_i(rx_req), .data_i(rx_data),
		.ack_o(rx_ack), .stb_o(rx_stb), .data_o(rx_byte)
	);

	wbm_spi u_wbm_spi (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.rx_stb_i(rx_stb), .rx_data_i(rx_byte), .tx_stb_o(tx_stb), .tx_data_o(tx_data),
		.wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_sel_o(wb_sel),
		.wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r),
		.wb_stall_i(wb_stall), .wb_ack_i(wb_ack)
	);

	cdc_export u_cdc_export (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .stb_i(tx_stb), .data_i(tx_data),
		.ack_i(tx_ack), .req_o(tx_req), .data_o(tx_data_x), .ready_o(tx_ready_o)
	);

	spi_byte_tx u_spi_byte_tx (
		.spi_sck_i(spi_sck_i), .spi_csn_i(spi_csn_i), .tx_req_i(tx_req),
		.tx_data_i(tx_data_x), .tx_ack_o(tx_ack), .spi_sdo_o(spi_sdo_o)
	);

	wb_word_ram u_wb_word_ram (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
		.wb_stall_o(wb_stall), .wb_ack_o(wb_ack)
	);

endmodule

`default_nettype wire

// File: source/wb_word_ram.sv
// Pipelined Wishbone slave word memory
// Fixed stall after each new strobe, fixed ack latency, byte-select writes
`timescale 1ns/1ps
`default_nettype none

module wb_word_ram import wbm_spi_pkg::*; (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	input  logic              wb_we_i,
	input  logic [sel_w-1:0]  wb_sel_i,
	input  logic [adr_w-1:0]  wb_adr_i,
	input  logic [word_w-1:0] wb_dat_i,
	output logic [word_w-1:0] wb_dat_o,
	output logic              wb_stall_o,
	output logic              wb_ack_o
);

	logic [word_w-1:0] mem [mem_words] = '{default: '0};
	logic [$clog2(mem_words)-1:0] word_idx;
	logic [stall_cnt_w-1:0] wait_cnt;  // Cycles this strobe has been stalled
	logic [ack_cycles-1:0] ack_pipe;
	logic accept;

	assign word_idx = wb_adr_i[$clog2(mem_words)+1:2]; // Word address
	assign wb_stall_o = wb_cyc_i && wb_stb_i && (wait_cnt < stall_cnt_w'(stall_cycles));
	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o;
	assign wb_ack_o = ack_pipe[ack_cycles-1];

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			wait_cnt <= '0;
			ack_pipe <= '0;
		end else begin
			if (wb_stall_o)
				wait_cnt <= wait_cnt + 1'b1;
			else
				wait_cnt <= '0; // Rearm for the next strobe
			ack_pipe <= (ack_pipe << 1) | ack_cycles'(accept);
		end
	end

	// Read before write, held until ack
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			wb_dat_o <= mem[word_idx];
			if (wb_we_i) begin
				for (int i = 0; i < sel_w; i++) begin
					if (wb_sel_i[i])
						mem[word_idx][i*byte_w +: byte_w] <= wb_dat_i[i*byte_w +: byte_w];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/wbm_spi.sv
// Command sequencer and pipelined Wishbone master
// Decodes command, address and write bytes, runs one bus cycle per command
// and queues one reply byte for every byte received
`timescale 1ns/1ps
`default_nettype none

module wbm_spi import wbm_spi_pkg::*; (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              rx_stb_i,
	input  logic [byte_w-1:0] rx_data_i,
	output logic              tx_stb_o,
	output logic [byte_w-1:0] tx_data_o,
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic              wb_we_o,
	output logic [sel_w-1:0]  wb_sel_o,
	output logic [adr_w-1:0]  wb_adr_o,
	output logic [word_w-1:0] wb_dat_o,
	input  logic [word_w-1:0] wb_dat_i,
	input  logic              wb_stall_i,
	input  logic              wb_ack_i
);

	seq_state_t state;
	logic [1:0] byte_idx;        // Data byte within the word
	logic [word_w-1:0] rd_word;  // Read data, shifted out MSB first

	// Sequencer and bus handshake
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= get_command;
			byte_idx <= 2'd0;
			tx_stb_o <= 1'b0;
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
		end else begin
			tx_stb_o <= rx_stb_i; // One reply per byte
			if (wb_stb_o && !wb_stall_i)
				wb_stb_o <= 1'b0; // Strobe accepted
			if (wb_ack_i)
				wb_cyc_o <= 1'b0;
			if (rx_stb_i) begin
				case (state)
				get_command: begin
					if (rx_data_i != '0) // 0x00 is idle filler
						state <= get_address;
				end
				get_address: begin
					byte_idx <= 2'd0;
					if (wb_we_o) begin
						state <= write_data; // Need the word first
					end else begin
						wb_cyc_o <= 1'b1;
						wb_stb_o <= 1'b1;
						state <= read_wait;
					end
				end
				write_data: begin
					byte_idx <= byte_idx + 2'd1;
					if (byte_idx == 2'd3) begin // Last byte in, launch
						wb_cyc_o <= 1'b1;
						wb_stb_o <= 1'b1;
						state <= write_wait;
					end
				end
				write_wait: begin
					if (!wb_cyc_o)
						state <= get_command;
				end
				read_wait: begin
					if (!wb_cyc_o) begin
						byte_idx <= 2'd0;
						state <= read_data;
					end
				end
				read_data: begin
					byte_idx <= byte_idx + 2'd1;
					if (byte_idx == 2'd3)
						state <= get_command;
				end
				default: state <= get_command;
				endcase
			end
		end
	end

	// Bus payload and reply bytes
	always_ff @(posedge wb_clk_i) begin
		if (wb_ack_i)
			rd_word <= wb_dat_i; // Only used after a read ack
		if (rx_stb_i) begin
			tx_data_o <= reply_wait;
			case (state)
			get_command: begin
				if (rx_data_i != '0) begin
					wb_we_o <= rx_data_i[byte_w-1];
					wb_sel_o <= rx_data_i[sel_w-1:0];
				end
			end
			get_address: wb_adr_o <= {{(adr_w - byte_w - 2){1'b0}}, rx_data_i, 2'b00};
			write_data: wb_dat_o <= {wb_dat_o[word_w-byte_w-1:0], rx_data_i}; // MSB first
			write_wait, read_wait: begin
				if (!wb_cyc_o)
					tx_data_o <= reply_ack;
			end
			read_data: begin
				tx_data_o <= rd_word[word_w-1 -: byte_w];
				rd_word <= rd_word << byte_w;
			end
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/cdc_export.sv
// Transmit crossing out of wb_clk_i
// Holds a strobed byte and toggles req for the SPI side, tracks the returned ack
`timescale 1ns/1ps
`default_nettype none

module cdc_export import wbm_spi_pkg::*; (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              stb_i,
	input  logic [byte_w-1:0] data_i,
	input  logic              ack_i,   // From the SPI clock domain
	output logic              req_o,
	output logic [byte_w-1:0] data_o,
	output logic              ready_o
);

	logic [1:0] ack_sync;

	// Low while a toggle is outstanding
	assign ready_o = (ack_sync[1] == req_o);

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			req_o <= 1'b0;
			ack_sync <= 2'b00;
		end else begin
			ack_sync <= {ack_sync[0], ack_i};
			if (stb_i)
				req_o <= ~req_o; // Same edge as the data
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (stb_i)
			data_o <= data_i;
	end

endmodule

`default_nettype wire

// File: source/cdc_import.sv
// Receive crossing into wb_clk_i
// Synchronizes a req toggle, strobes the byte for one cycle and returns the ack
`timescale 1ns/1ps
`default_nettype none

module cdc_import import wbm_spi_pkg::*; (
	input  logic              wb_clk_i,
	input  logic              wb_rst_i,
	input  logic              req_i,   // Toggles once per byte
	input  logic [byte_w-1:0] data_i,  // Held stable around the toggle
	output logic              ack_o,
	output logic              stb_o,
	output logic [byte_w-1:0] data_o
);

	logic [1:0] req_sync; // Two-flop synchronizer

	// New toggle not yet acknowledged
	assign stb_o = req_sync[1] ^ ack_o;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			req_sync <= 2'b00;
			ack_o <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], req_i};
			if (stb_o)
				ack_o <= req_sync[1]; // Ends the strobe after one cycle
		end
	end

	// Sampled while idle, frozen during the strobe
	// Data settled two cycles before the toggle is seen
	always_ff @(posedge wb_clk_i) begin
		if (!stb_o)
			data_o <= data_i;
	end

endmodule

`default_nettype wire

// File: source/spi_byte_tx.sv
// SPI transmit shifter, mode 0, MSB first
// Takes a reply byte over a req/ack toggle and shifts it out on SCK falling edges
`timescale 1ns/1ps
`default_nettype none

module spi_byte_tx import wbm_spi_pkg::*; (
	input  logic              spi_sck_i,
	input  logic              spi_csn_i,
	input  logic              tx_req_i,
	input  logic [byte_w-1:0] tx_data_i,
	output logic              tx_ack_o,
	output logic              spi_sdo_o
);

	logic [2:0] bit_cnt;         // Falling edges in the current byte
	logic [byte_w-1:0] shift_q;
	logic at_boundary;

	assign at_boundary = (bit_cnt == 3'(byte_w - 1));
	assign spi_sdo_o = shift_q[byte_w-1]; // Bit 7 valid as soon as CSn falls

	always_ff @(negedge spi_sck_i or posedge spi_csn_i) begin
		if (spi_csn_i) begin
			bit_cnt <= 3'd0;
			shift_q <= reply_wait; // Nothing queued yet
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (at_boundary) begin
				if (tx_req_i != tx_ack_o)
					shift_q <= tx_data_i; // Fresh reply
				else
					shift_q <= reply_wait;
			end else begin
				shift_q <= {shift_q[byte_w-2:0], 1'b0};
			end
		end
	end

	// Ack follows req at every boundary
	always_ff @(negedge spi_sck_i) begin
		if (!spi_csn_i && at_boundary)
			tx_ack_o <= tx_req_i;
	end

endmodule

`default_nettype wire

// File: source/spi_byte_rx.sv
// SPI receive shifter, mode 0, MSB first
// Assembles bytes on the SCK rising edge and offers each one on a req/ack toggle
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx import wbm_spi_pkg::*; (
	input  logic              spi_sck_i,
	input  logic              spi_csn_i,
	input  logic              spi_sdi_i,
	input  logic              rx_ack_i,  // Returned toggle from the Wishbone side
	output logic              rx_req_o,
	output logic [byte_w-1:0] rx_data_o
);

	logic [2:0] bit_cnt;          // Bits taken in the current byte
	logic [byte_w-2:0] shift_q;   // First seven bits of the byte
	logic byte_done;

	assign byte_done = (bit_cnt == 3'(byte_w - 1));

	// Framing, cleared while deselected
	always_ff @(posedge spi_sck_i or posedge spi_csn_i) begin
		if (spi_csn_i) begin
			bit_cnt <= 3'd0;
			shift_q <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1; // Wraps at the byte boundary
			shift_q <= {shift_q[byte_w-3:0], spi_sdi_i};
		end
	end

	// Holding register and request toggle
	always_ff @(posedge spi_sck_i) begin
		if (!spi_csn_i && byte_done) begin
			rx_data_o <= {shift_q, spi_sdi_i}; // Last bit straight from the pin
			rx_req_o <= ~rx_ack_i;              // Previous crossing is long done
		end
	end

endmodule

`default_nettype wire

// File: source/wbm_spi_pkg.sv
// SPI to Wishbone bridge shared definitions
// Bus widths, sequencer states, reply codes and slave memory timing
`default_nettype none

package wbm_spi_pkg;

	localparam int byte_w = 8;       // One SPI byte
	localparam int word_w = 32;      // Wishbone data
	localparam int adr_w = 16;       // Wishbone byte address
	localparam int sel_w = word_w / byte_w;

	// Slave memory, one word per address byte value
	localparam int mem_words = 256;
	localparam int stall_cycles = 1; // Stall held after a new strobe
	localparam int ack_cycles = 2;   // Accept to ack
	localparam int stall_cnt_w = $clog2(stall_cycles + 1);

	// Reply codes seen by the MCU
	localparam logic [byte_w-1:0] reply_wait = 8'h00; // Cycle still pending
	localparam logic [byte_w-1:0] reply_ack = 8'h01;  // Ack seen

	// Sequencer states, data bytes counted by a separate index
	typedef enum logic [2:0] {
		get_command,
		get_address,
		read_wait,
		read_data,
		write_data,
		write_wait
	} seq_state_t;

endpackage

`default_nettype wire
